// File: nexus_settings.svh
`ifndef NEXUS_SETTINGS_SVH
`define NEXUS_SETTINGS_SVH

// Clock cycles per serial bit on both UART ports
// Receiver and transmitter both assume an even value
`define NEXUS_CLKS_PER_BIT 8

// Size of the register memory in bytes
`define NEXUS_MEM_DEPTH 16

// Address bits needed to index the register memory
// Must match the memory depth above
`define NEXUS_ADDR_W 4

// Number of UART ports served by the controller
`define NEXUS_PORTS 2

`endif

// File: nexus_pkg.sv
`default_nettype none

// Types and constants shared by the debug controller and its testbench
package nexus_pkg;

  // Every data path in the design carries plain bytes
  typedef logic [7:0] byte_t;

  // First byte of each three-byte command frame
  // Any other value is treated as an unknown opcode and faults
  typedef enum logic [7:0] {
    OP_WRITE = 8'h01,
    OP_READ  = 8'h02,
    OP_HALT  = 8'h03
  } opcode_e;

  // Returned for an unknown opcode or an address past the end of memory
  localparam byte_t RSP_ERROR = 8'hEE;

  // Returned once for the halt command, an ASCII 'H'
  localparam byte_t RSP_HALT = 8'h48;

endpackage

`default_nettype wire

// File: uart_rx.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

// 8N1 serial receiver, one byte per valid strobe
module uart_rx (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             rx_i,
  output nexus_pkg::byte_t rx_byte_o,
  output logic             rx_valid_o
);
  import nexus_pkg::*;

  localparam int CPB   = `NEXUS_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  byte_t            shreg;
  logic             bit_end;

  // Marks the middle of a data or stop bit, one full period after the last sample
  assign bit_end = (clk_cnt == CNT_W'(CPB - 1));

  // The shift register is left alone during the stop bit, so it is the byte
  assign rx_byte_o = shreg;

  // Two flops bring the asynchronous line into the clock domain
  // They reset to the idle level so no false start bit is seen
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state      <= RX_IDLE;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      shreg      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // The valid strobe lasts a single cycle
      rx_valid_o <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          // A falling edge on the synchronised line may be a start bit
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Half a bit later the start bit must still be low, else it was a glitch
          if (clk_cnt == CNT_W'(CPB / 2 - 1)) begin
            clk_cnt <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            // Least significant bit arrives first, so shift in from the top
            shreg   <= {rx_sync, shreg[7:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            // A low stop bit is a framing error and the byte is dropped
            rx_valid_o <= rx_sync;
            state      <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

// 8N1 serial transmitter driven by a four-phase request
module uart_tx (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             tx_req_i,
  input  nexus_pkg::byte_t tx_byte_i,
  output logic             tx_ack_o,
  output logic             tx_o
);
  import nexus_pkg::*;

  localparam int CPB   = `NEXUS_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);

  typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_DONE} tx_state_e;

  tx_state_e        state;
  logic [CNT_W-1:0] clk_cnt;
  // Counts start bit as 0, data bits as 1 to 8 and the stop bit as 9
  logic [3:0]       bit_cnt;
  byte_t            shreg;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state    <= TX_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      shreg    <= '0;
      tx_ack_o <= 1'b0;
      tx_o     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          // The request is only seen here after the previous one fell
          if (tx_req_i) begin
            shreg   <= tx_byte_i;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_o    <= 1'b0;
            state   <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (clk_cnt == CNT_W'(CPB - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
              // Stop bit has run for a full period
              tx_ack_o <= 1'b1;
              state    <= TX_DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt < 4'd8) begin
                // Data goes out least significant bit first
                tx_o  <= shreg[0];
                shreg <= shreg >> 1;
              end else begin
                tx_o <= 1'b1;
              end
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_DONE: begin
          // Hold the ack until the controller lets go of the request
          if (!tx_req_i) begin
            tx_ack_o <= 1'b0;
            state    <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cmd_framer.sv
`default_nettype none
`timescale 1ns/10ps

// Assembles opcode, address and data bytes into one command
module cmd_framer (
  input  logic             clk_i,
  input  logic             rst_i,
  input  nexus_pkg::byte_t rx_byte_i,
  input  logic             rx_valid_i,
  input  logic             cmd_ack_i,
  output logic             cmd_req_o,
  output nexus_pkg::byte_t cmd_op_o,
  output nexus_pkg::byte_t cmd_addr_o,
  output nexus_pkg::byte_t cmd_data_o
);
  import nexus_pkg::*;

  // Byte positions 0 to 2 fill the fields, position 3 holds the handshake
  localparam logic [1:0] POS_OP   = 2'd0;
  localparam logic [1:0] POS_ADDR = 2'd1;
  localparam logic [1:0] POS_DATA = 2'd2;
  localparam logic [1:0] POS_WAIT = 2'd3;

  logic [1:0] pos;
  logic       accept;

  // Bytes arriving during the handshake are dropped, which is the only back-pressure
  assign accept = rx_valid_i && !cmd_req_o && !cmd_ack_i && (pos != POS_WAIT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pos       <= POS_OP;
      cmd_req_o <= 1'b0;
    end else begin
      if (accept) begin
        if (pos == POS_DATA) begin
          // Third byte is in, offer the command on the next cycle
          cmd_req_o <= 1'b1;
          pos       <= POS_WAIT;
        end else begin
          pos <= pos + 1'b1;
        end
      end else if (cmd_req_o && cmd_ack_i) begin
        // Controller is done with the fields
        cmd_req_o <= 1'b0;
      end else if ((pos == POS_WAIT) && !cmd_req_o && !cmd_ack_i) begin
        // Ack has fallen, so the next frame may start
        pos <= POS_OP;
      end
    end
  end

  // The fields only change while no request is up, so they are stable during it
  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (pos)
        POS_OP:   cmd_op_o   <= rx_byte_i;
        POS_ADDR: cmd_addr_o <= rx_byte_i;
        default:  cmd_data_o <= rx_byte_i;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: nexus_mem.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

// Register memory behind a four-phase request
module nexus_mem (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     mem_req_i,
  input  logic                     mem_we_i,
  input  logic [`NEXUS_ADDR_W-1:0] mem_addr_i,
  input  nexus_pkg::byte_t         mem_wdata_i,
  output logic                     mem_ack_o,
  output nexus_pkg::byte_t         mem_rdata_o
);
  import nexus_pkg::*;

  byte_t regs [`NEXUS_MEM_DEPTH];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // A debug read after reset must return zero
      for (int i = 0; i < `NEXUS_MEM_DEPTH; i++) begin
        regs[i] <= '0;
      end
      mem_ack_o   <= 1'b0;
      mem_rdata_o <= '0;
    end else if (mem_req_i && !mem_ack_o) begin
      // Access happens once, on the first cycle of the request
      if (mem_we_i) begin
        regs[mem_addr_i] <= mem_wdata_i;
      end
      mem_rdata_o <= regs[mem_addr_i];
      mem_ack_o   <= 1'b1;
    end else if (!mem_req_i) begin
      mem_ack_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: nexus_ctrl.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

// Round-robin command executor for all UART ports
module nexus_ctrl (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic [`NEXUS_PORTS-1:0]                     cmd_req_i,
  input  nexus_pkg::byte_t [`NEXUS_PORTS-1:0]         cmd_op_i,
  input  nexus_pkg::byte_t [`NEXUS_PORTS-1:0]         cmd_addr_i,
  input  nexus_pkg::byte_t [`NEXUS_PORTS-1:0]         cmd_data_i,
  output logic [`NEXUS_PORTS-1:0]                     cmd_ack_o,
  output logic                                        mem_req_o,
  output logic                                        mem_we_o,
  output logic [`NEXUS_ADDR_W-1:0]                    mem_addr_o,
  output nexus_pkg::byte_t                            mem_wdata_o,
  input  logic                                        mem_ack_i,
  input  nexus_pkg::byte_t                            mem_rdata_i,
  output logic [`NEXUS_PORTS-1:0]                     tx_req_o,
  output nexus_pkg::byte_t [`NEXUS_PORTS-1:0]         tx_byte_o,
  input  logic [`NEXUS_PORTS-1:0]                     tx_ack_i,
  output logic                                        halted_o,
  output logic                                        fault_o
);
  import nexus_pkg::*;

  localparam int SEL_W = $clog2(`NEXUS_PORTS);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DECODE,
    ST_MEMORY,
    ST_RESPOND,
    ST_ACK,
    ST_HALTED
  } ctrl_state_e;

  ctrl_state_e      state;
  logic [SEL_W-1:0] sel;
  logic [SEL_W-1:0] prio;
  logic [SEL_W-1:0] alt;
  byte_t            rsp;
  byte_t            cur_op;
  byte_t            cur_addr;
  byte_t            cur_data;
  logic             addr_ok;
  logic             is_mem_op;

  // Port that loses a tie in the current round
  assign alt = SEL_W'(prio + 1'b1);

  // Framer fields hold still while the request is up, so no copy is taken
  assign cur_op   = cmd_op_i[sel];
  assign cur_addr = cmd_addr_i[sel];
  assign cur_data = cmd_data_i[sel];

  assign addr_ok   = (cur_addr < 8'(`NEXUS_MEM_DEPTH));
  assign is_mem_op = (cur_op == OP_WRITE) || (cur_op == OP_READ);

  // Only the transmitter being requested loads the byte
  assign tx_byte_o = {`NEXUS_PORTS{rsp}};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state       <= ST_IDLE;
      sel         <= '0;
      prio        <= '0;
      rsp         <= '0;
      cmd_ack_o   <= '0;
      mem_req_o   <= 1'b0;
      mem_we_o    <= 1'b0;
      mem_addr_o  <= '0;
      mem_wdata_o <= '0;
      tx_req_o    <= '0;
      halted_o    <= 1'b0;
      fault_o     <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // The port holding priority wins, otherwise the other one is served
          if (cmd_req_i[prio]) begin
            sel   <= prio;
            state <= ST_DECODE;
          end else if (cmd_req_i[alt]) begin
            sel   <= alt;
            state <= ST_DECODE;
          end
        end
        ST_DECODE: begin
          if (cur_op == OP_HALT) begin
            rsp      <= RSP_HALT;
            halted_o <= 1'b1;
            state    <= ST_RESPOND;
          end else if (is_mem_op && addr_ok) begin
            mem_we_o    <= (cur_op == OP_WRITE);
            mem_addr_o  <= cur_addr[`NEXUS_ADDR_W-1:0];
            mem_wdata_o <= cur_data;
            state       <= ST_MEMORY;
          end else begin
            // Fault is sticky until reset
            rsp     <= RSP_ERROR;
            fault_o <= 1'b1;
            state   <= ST_RESPOND;
          end
        end
        ST_MEMORY: begin
          if (!mem_req_o) begin
            // Wait for the last ack to clear before a new request
            if (!mem_ack_i) begin
              mem_req_o <= 1'b1;
            end
          end else if (mem_ack_i) begin
            mem_req_o <= 1'b0;
            // A write echoes its own data, a read returns what the memory held
            rsp       <= mem_we_o ? mem_wdata_o : mem_rdata_i;
            state     <= ST_RESPOND;
          end
        end
        ST_RESPOND: begin
          if (!tx_req_o[sel] && !tx_ack_i[sel]) begin
            tx_req_o[sel] <= 1'b1;
          end else if (tx_req_o[sel] && tx_ack_i[sel]) begin
            // Stop bit is out, release the transmitter and finish the command
            tx_req_o[sel]  <= 1'b0;
            cmd_ack_o[sel] <= 1'b1;
            state          <= ST_ACK;
          end
        end
        ST_ACK: begin
          if (!cmd_req_i[sel]) begin
            cmd_ack_o[sel] <= 1'b0;
            // The other port gets first pick next round
            prio           <= SEL_W'(sel + 1'b1);
            state          <= halted_o ? ST_HALTED : ST_IDLE;
          end
        end
        ST_HALTED: begin
          // No more commands are taken until reset
          state <= ST_HALTED;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: nexus_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

// Two-port UART debug controller with status pins
module nexus_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`NEXUS_PORTS-1:0] uart_rx_i,
  output logic [`NEXUS_PORTS-1:0] uart_tx_o,
  output logic                    halted_o,
  output logic                    fault_o,
  output logic                    halted_n_o,
  output logic                    fault_n_o
);
  import nexus_pkg::*;

  byte_t [`NEXUS_PORTS-1:0] rx_byte;
  logic  [`NEXUS_PORTS-1:0] rx_valid;
  logic  [`NEXUS_PORTS-1:0] cmd_req;
  logic  [`NEXUS_PORTS-1:0] cmd_ack;
  byte_t [`NEXUS_PORTS-1:0] cmd_op;
  byte_t [`NEXUS_PORTS-1:0] cmd_addr;
  byte_t [`NEXUS_PORTS-1:0] cmd_data;
  logic  [`NEXUS_PORTS-1:0] tx_req;
  logic  [`NEXUS_PORTS-1:0] tx_ack;
  byte_t [`NEXUS_PORTS-1:0] tx_byte;

  logic                     mem_req;
  logic                     mem_we;
  logic [`NEXUS_ADDR_W-1:0] mem_addr;
  byte_t                    mem_wdata;
  logic                     mem_ack;
  byte_t                    mem_rdata;

  // Board pins expect the status lines active low as well
  assign halted_n_o = ~halted_o;
  assign fault_n_o  = ~fault_o;

  // Each port has its own receiver, framer and transmitter
  for (genvar p = 0; p < `NEXUS_PORTS; p++) begin : g_port
    uart_rx u_rx (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rx_i       (uart_rx_i[p]),
      .rx_byte_o  (rx_byte[p]),
      .rx_valid_o (rx_valid[p])
    );

    cmd_framer u_framer (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .rx_byte_i  (rx_byte[p]),
      .rx_valid_i (rx_valid[p]),
      .cmd_ack_i  (cmd_ack[p]),
      .cmd_req_o  (cmd_req[p]),
      .cmd_op_o   (cmd_op[p]),
      .cmd_addr_o (cmd_addr[p]),
      .cmd_data_o (cmd_data[p])
    );

    uart_tx u_tx (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .tx_req_i  (tx_req[p]),
      .tx_byte_i (tx_byte[p]),
      .tx_ack_o  (tx_ack[p]),
      .tx_o      (uart_tx_o[p])
    );
  end

  nexus_mem u_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  nexus_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_req_i   (cmd_req),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_data_i  (cmd_data),
    .cmd_ack_o   (cmd_ack),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata),
    .tx_req_o    (tx_req),
    .tx_byte_o   (tx_byte),
    .tx_ack_i    (tx_ack),
    .halted_o    (halted_o),
    .fault_o     (fault_o)
  );

endmodule

`default_nettype wire

// File: tb_nexus.sv
`default_nettype none
`timescale 1ns/10ps
`include "nexus_settings.svh"

module tb_nexus;
  import nexus_pkg::*;

  localparam int CPB          = `NEXUS_CLKS_PER_BIT;
  // Frames sent over all tests, the halt window counted as one more
  localparam int NUM_FRAMES   = 23;
  // One frame is budgeted 60 bit periods, which also sizes the halt window
  localparam int FRAME_CYCLES = 60 * CPB;
  localparam int LIMIT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 200;

  logic                    clk;
  logic                    rst;
  logic [`NEXUS_PORTS-1:0] rx_line;
  logic [`NEXUS_PORTS-1:0] tx_line;
  logic                    halted;
  logic                    fault;
  logic                    halted_n;
  logic                    fault_n;

  // Shadow state of the reference model
  byte_t       shadow_mem [`NEXUS_MEM_DEPTH];
  logic        exp_halted;
  logic        exp_fault;
  logic [31:0] lcg_state;

  // Expected bytes come from the model, actual bytes from the serial monitors
  byte_t exp_q0 [$];
  byte_t exp_q1 [$];
  byte_t act_q0 [$];
  byte_t act_q1 [$];

  int cycle_cnt;
  int err_cnt;
  int check_cnt;
  int tests_run;
  int tests_failed;
  int test_err_start;

  nexus_top UUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .uart_rx_i  (rx_line),
    .uart_tx_o  (tx_line),
    .halted_o   (halted),
    .fault_o    (fault),
    .halted_n_o (halted_n),
    .fault_n_o  (fault_n)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // The upper bits of an LCG are the better distributed ones
    return lcg_state[23:16];
  endfunction

  // Applies one command to the shadow state and returns the byte the DUT should send
  function automatic byte_t ref_response(input byte_t op, input byte_t addr, input byte_t data);
    byte_t r;
    // Halt is decoded before the address is looked at
    if (op == OP_HALT) begin
      exp_halted = 1'b1;
      r = RSP_HALT;
    end else if ((op == OP_WRITE || op == OP_READ) && addr < `NEXUS_MEM_DEPTH) begin
      if (op == OP_WRITE) begin
        shadow_mem[addr[`NEXUS_ADDR_W-1:0]] = data;
        r = data;
      end else begin
        r = shadow_mem[addr[`NEXUS_ADDR_W-1:0]];
      end
    end else begin
      exp_fault = 1'b1;
      r = RSP_ERROR;
    end
    return r;
  endfunction

  function automatic void reset_model();
    for (int i = 0; i < `NEXUS_MEM_DEPTH; i++) begin
      shadow_mem[i] = '0;
    end
    exp_halted = 1'b0;
    exp_fault  = 1'b0;
  endfunction

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    check_cnt++;
    if (act !== exp) begin
      $display("error: %s expected 0x%02h got 0x%02h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      $display("error: %s expected 0x%0h got 0x%0h", name, exp, act);
      err_cnt++;
    end
  endtask

  // Each bit is held for one full bit period, changed on the rising edge
  task automatic drive_bit(input int p, input logic b);
    @(posedge clk);
    rx_line[p] <= b;
    repeat (CPB - 1) @(posedge clk);
  endtask

  task automatic send_byte(input int p, input byte_t b);
    drive_bit(p, 1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(p, b[i]);
    end
    drive_bit(p, 1'b1);
  endtask

  task automatic send_frame(input int p, input byte_t op, input byte_t addr, input byte_t data);
    send_byte(p, op);
    send_byte(p, addr);
    send_byte(p, data);
  endtask

  // A halted controller answers nothing, so no byte is expected then
  task automatic issue_cmd(input int p, input byte_t op, input byte_t addr, input byte_t data);
    byte_t e;
    if (!exp_halted) begin
      e = ref_response(op, addr, data);
      if (p == 0) begin
        exp_q0.push_back(e);
      end else begin
        exp_q1.push_back(e);
      end
    end
    send_frame(p, op, addr, data);
  endtask

  // The watchdog bounds this wait if a response never comes
  task automatic wait_responses();
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Any low level on a tx line inside the window is a start bit
  task automatic watch_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (tx_line !== '1) begin
        $display("a start bit was sent after the halt at cycle %0d", cycle_cnt);
        err_cnt++;
        i = cycles;
      end
    end
  endtask

  // Samples one response byte at the middle of each bit
  task automatic collect_byte(input int p, output byte_t b, output logic stop_ok);
    b = '0;
    @(negedge clk);
    while (tx_line[p] !== 1'b0) begin
      @(negedge clk);
    end
    repeat (CPB / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      b[i] = tx_line[p];
    end
    repeat (CPB) @(negedge clk);
    stop_ok = tx_line[p];
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (err_cnt != test_err_start) begin
      tests_failed++;
    end
    $display("test %0d %s %s", num, name,
             (err_cnt == test_err_start) ? "passed" : "failed");
    test_err_start = err_cnt;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_model();
  endtask

  initial begin
    byte_t b;
    logic  ok;
    forever begin
      collect_byte(0, b, ok);
      if (!ok) begin
        $display("port 0 response frame has a low stop bit");
        err_cnt++;
      end
      act_q0.push_back(b);
    end
  end

  initial begin
    byte_t b;
    logic  ok;
    forever begin
      collect_byte(1, b, ok);
      if (!ok) begin
        $display("port 1 response frame has a low stop bit");
        err_cnt++;
      end
      act_q1.push_back(b);
    end
  end

  // Pairs each received byte with the oldest expected byte of its port
  initial begin
    byte_t e;
    byte_t a;
    forever begin
      @(posedge clk);
      if (act_q0.size() != 0) begin
        a = act_q0.pop_front();
        if (exp_q0.size() == 0) begin
          $display("port 0 sent byte 0x%02h when no response was due", a);
          err_cnt++;
        end else begin
          e = exp_q0.pop_front();
          check_byte("uart_tx_o[0]", e, a);
        end
      end
      if (act_q1.size() != 0) begin
        a = act_q1.pop_front();
        if (exp_q1.size() == 0) begin
          $display("port 1 sent byte 0x%02h when no response was due", a);
          err_cnt++;
        end else begin
          e = exp_q1.pop_front();
          check_byte("uart_tx_o[1]", e, a);
        end
      end
    end
  end

  initial begin
    while (cycle_cnt < LIMIT_CYCLES) begin
      @(posedge clk);
    end
    $display("timed out after %0d cycles", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    byte_t addrs [5];
    byte_t a0;
    byte_t a1;
    cycle_cnt      = 0;
    err_cnt        = 0;
    check_cnt      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    lcg_state      = 32'd54721;
    rst            = 1'b1;
    rx_line        = '1;
    reset_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);

    // Writes go in on port 0 and are read back on port 1
    for (int i = 0; i < 5; i++) begin
      addrs[i] = rand_byte() & 8'h0F;
      issue_cmd(0, OP_WRITE, addrs[i], rand_byte());
      wait_responses();
    end
    for (int i = 0; i < 5; i++) begin
      issue_cmd(1, OP_READ, addrs[i], 8'h00);
      wait_responses();
    end
    end_test(1, "write then read");

    // Distinct addresses keep the model valid for either arbiter order
    a0 = 8'h02;
    a1 = 8'h09;
    fork
      issue_cmd(0, OP_WRITE, a0, rand_byte());
      issue_cmd(1, OP_WRITE, a1, rand_byte());
    join
    wait_responses();
    fork
      issue_cmd(0, OP_READ, a1, 8'h00);
      issue_cmd(1, OP_READ, a0, 8'h00);
    join
    wait_responses();
    end_test(2, "concurrent ports");

    check_flag("fault_o", 1'b0, fault);
    check_flag("fault_n_o", 1'b1, fault_n);
    issue_cmd(1, 8'h7F, 8'h01, 8'h55);
    wait_responses();
    check_flag("fault_o", 1'b1, fault);
    check_flag("fault_n_o", 1'b0, fault_n);
    // The fault is sticky but service goes on
    issue_cmd(0, OP_WRITE, 8'h05, 8'hC3);
    wait_responses();
    issue_cmd(1, OP_READ, 8'h05, 8'h00);
    wait_responses();
    check_flag("fault_o", exp_fault, fault);
    end_test(3, "bad opcode");

    // Reset clears the sticky fault so the range error has to set it again
    apply_reset();
    @(negedge clk);
    check_flag("fault_o", 1'b0, fault);
    // Address 0x13 would alias to 3 if the range check were missing
    issue_cmd(0, OP_WRITE, 8'h13, 8'hA5);
    wait_responses();
    check_flag("fault_o", 1'b1, fault);
    issue_cmd(1, OP_READ, 8'h03, 8'h00);
    wait_responses();
    check_flag("fault_o", exp_fault, fault);
    end_test(4, "address out of range");

    issue_cmd(0, OP_HALT, 8'h00, 8'h00);
    wait_responses();
    check_flag("halted_o", 1'b1, halted);
    check_flag("halted_n_o", 1'b0, halted_n);
    fork
      issue_cmd(1, OP_READ, 8'h02, 8'h00);
      watch_idle(FRAME_CYCLES);
    join
    end_test(5, "halt");

    apply_reset();
    repeat (2) @(negedge clk);
    check_flag("halted_o", 1'b0, halted);
    check_flag("fault_o", 1'b0, fault);
    check_flag("uart_tx_o[0]", 1'b1, tx_line[0]);
    check_flag("uart_tx_o[1]", 1'b1, tx_line[1]);
    issue_cmd(0, OP_READ, a0, 8'h00);
    wait_responses();
    end_test(6, "reset");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
nexus_pkg.sv
uart_rx.sv
uart_tx.sv
cmd_framer.sv
nexus_mem.sv
nexus_ctrl.sv
nexus_top.sv
tb_nexus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -j 0 -Wno-fatal --top-module tb_nexus -f files.f -o Vtb_nexus

./obj_dir/Vtb_nexus | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAIL"
  exit 1
fi

echo "run_sim: PASS"
exit 0
